// File: aes256_enc.sv
// ------------------------------
// aes256_enc
// iterative AES-256 encryption core,
// fixed key, register write port
// ------------------------------
`timescale 1ns/1ps

module aes256_enc (
    input  logic            clk,
    input  logic            resetn,
    input  aes_pkg::write_t wr,
    output logic            busy,
    output logic            out_valid,
    output aes_pkg::state_t out_block
);
    import aes_pkg::*;

    dp_ctrl_t dp;
    state_t   plain;
    state_t   shifted;
    state_t   mixed;

    aes_ctrl i_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .wr        (wr),
        .dp        (dp),
        .busy      (busy),
        .out_valid (out_valid)
    );

    aes_in_buffer i_in_buffer (
        .clk    (clk),
        .resetn (resetn),
        .wr     (wr),
        .busy   (busy),
        .block  (plain)
    );

    // serializer reads the key addition result
    aes_sub_shift i_sub_shift (
        .clk      (clk),
        .resetn   (resetn),
        .dp       (dp),
        .state_in (out_block),
        .shifted  (shifted)
    );

    aes_mix_columns i_mix_columns (
        .clk      (clk),
        .resetn   (resetn),
        .dp       (dp),
        .state_in (shifted),
        .mixed    (mixed)
    );

    aes_add_round_key i_add_round_key (
        .clk       (clk),
        .resetn    (resetn),
        .dp        (dp),
        .plain     (plain),
        .shifted   (shifted),
        .mixed     (mixed),
        .state_out (out_block)
    );

endmodule

// File: aes256_enc_tb.sv
// ------------------------------
// aes256_enc_tb
// self-checking testbench, vectors from
// the test data file
// ------------------------------
`timescale 1ns/1ps

module aes256_enc_tb;
    import aes_pkg::*;

    localparam int NUM_VEC = 8;
    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLES_PER_RUN = 400;
    // vector runs plus the extra runs of the later tests
    localparam int NUM_RUNS = NUM_VEC + 6;

    logic     clk;
    logic     resetn;
    write_t   wr;
    logic     busy;
    logic     out_valid;
    state_t   out_block;

    // plaintext at even, ciphertext at odd entries
    logic [127:0] vec_mem [0:2*NUM_VEC-1];
    word_t        rng_state;
    int           pulse_cnt;

    aes256_enc i_aes256_enc (
        .clk       (clk),
        .resetn    (resetn),
        .wr        (wr),
        .busy      (busy),
        .out_valid (out_valid),
        .out_block (out_block)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // counts cycles with out_valid high
    always @(posedge clk)
    begin
        if (!resetn)
            pulse_cnt <= 0;
        else if (out_valid)
            pulse_cnt <= pulse_cnt + 1;
    end

    // xorshift32
    function automatic word_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_state(input string name, input state_t expected, input state_t actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // one strobe, then a quiet cycle
    task automatic write_word(input logic addr_bit, input word_t data);
        @(posedge clk);
        wr <= '{valid: 1'b1, addr: addr_bit, data: data};
        @(posedge clk);
        wr <= '0;
    endtask

    // first word becomes column 0
    task automatic load_block(input state_t pt);
        for (int c = 0; c < 4; c++)
            write_word(1'b1, pt[4*c +: 4]);
    endtask

    task automatic start_run();
        write_word(1'b0, word_t'(1) << CTRL_START_BIT);
    endtask

    // result on the pulse, then pulse width and hold
    task automatic wait_result(output state_t result);
        @(negedge clk);
        while (out_valid !== 1'b1)
            @(negedge clk);
        result = out_block;
        @(negedge clk);
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("busy", 1'b0, busy);
        check_state("out_block", result, out_block);
    endtask

    task automatic check_pulses(input int since);
        if (pulse_cnt - since != 1)
        begin
            $display("expected one out_valid pulse in the run, counted %0d", pulse_cnt - since);
            abort_run();
        end
    endtask

    // timeout if the core never answers
    initial
    begin
        repeat (NUM_RUNS * CYCLES_PER_RUN + RESET_CYCLES) @(posedge clk);
        $display("time limit reached and out_valid never came");
        abort_run();
    end

    initial
    begin
        state_t pt;
        state_t ct;
        state_t res;
        state_t prev;
        int     pulses;
        resetn = 1'b0;
        wr = '0;
        rng_state = 32'd63561;
        $readmemh("aes_testdata.txt", vec_mem);
        if ($isunknown(vec_mem[2*NUM_VEC-1]))
        begin
            $display("test data file is missing or holds too few pairs");
            abort_run();
        end
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;

        // idle outputs after reset
        idle_cycles(2);
        check_bit("busy", 1'b0, busy);
        check_bit("out_valid", 1'b0, out_valid);

        // FIPS-197 C.3 vector
        load_block(state_t'(vec_mem[0]));
        start_run();
        wait_result(res);
        check_state("out_block", state_t'(vec_mem[1]), res);

        // every pair in turn
        for (int i = 0; i < NUM_VEC; i++)
        begin
            load_block(state_t'(vec_mem[2*i]));
            start_run();
            wait_result(res);
            check_state("out_block", state_t'(vec_mem[2*i+1]), res);
        end

        // data writes and a second start while busy
        pt = state_t'(vec_mem[2*(NUM_VEC-1)]);
        ct = state_t'(vec_mem[2*(NUM_VEC-1)+1]);
        load_block(pt);
        idle_cycles(1);
        pulses = pulse_cnt;
        start_run();
        while (!busy)
            @(negedge clk);
        for (int i = 0; i < 6; i++)
            write_word(1'b1, next_rand());
        start_run();
        wait_result(res);
        check_state("out_block", ct, res);
        idle_cycles(40);
        check_pulses(pulses);
        check_bit("busy", 1'b0, busy);
        // buffer must still hold the block from before the run
        pulses = pulse_cnt;
        start_run();
        wait_result(res);
        check_state("out_block", ct, res);
        idle_cycles(2);
        check_pulses(pulses);

        // only the last four of six words count
        write_word(1'b1, next_rand());
        write_word(1'b1, next_rand());
        load_block(state_t'(vec_mem[0]));
        start_run();
        wait_result(res);
        check_state("out_block", state_t'(vec_mem[1]), res);

        // result holds while idle and across new data writes
        prev = res;
        idle_cycles(20);
        check_state("out_block", prev, out_block);
        load_block(pt);
        idle_cycles(1);
        check_state("out_block", prev, out_block);
        pulses = pulse_cnt;
        start_run();
        wait_result(res);
        check_state("out_block", ct, res);
        idle_cycles(2);
        check_pulses(pulses);

        $display("all tests passed");
        $finish;
    end

endmodule

// File: aes_add_round_key.sv
// ------------------------------
// aes_add_round_key
// round state register and round
// key addition from the key table
// ------------------------------
`timescale 1ns/1ps

module aes_add_round_key (
    input  logic              clk,
    input  logic              resetn,
    input  aes_pkg::dp_ctrl_t dp,
    input  aes_pkg::state_t   plain,
    input  aes_pkg::state_t   shifted,
    input  aes_pkg::state_t   mixed,
    output aes_pkg::state_t   state_out
);
    import aes_pkg::*;

    state_t state_q;
    state_t ark_in;

    // plaintext only in round 0
    assign ark_in = dp.sel_plain ? plain : state_q;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state_q <= '0;
            state_out <= '0;
        end
        else
        begin
            // last round stores the unmixed state
            if (dp.store_en)
                state_q <= dp.store_sel ? mixed : shifted;
            // held until the next key addition
            if (dp.ark_en)
                state_out <= ark_in ^ ROUND_KEYS[dp.round];
        end
    end

endmodule

// File: aes_ctrl.sv
// ------------------------------
// aes_ctrl
// round sequencing FSM, s-box byte
// counter and datapath enables
// ------------------------------
`timescale 1ns/1ps

module aes_ctrl (
    input  logic              clk,
    input  logic              resetn,
    input  aes_pkg::write_t   wr,
    output aes_pkg::dp_ctrl_t dp,
    output logic              busy,
    output logic              out_valid
);
    import aes_pkg::*;

    ctrl_st_e  st;
    ctrl_st_e  st_next;
    round_t    round;
    byte_idx_t byte_cnt;
    logic      start;
    logic      last_round;

    assign busy = (st != idle);
    assign out_valid = (st == done);
    // 14th round skips mixcolumns
    assign last_round = (round == round_t'(NUM_ROUNDS - 1));

    // start flag written at addr 0 while idle
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            start <= 1'b0;
        else if (st == done)
            start <= 1'b0;
        else if (wr.valid && !wr.addr && !busy)
            start <= wr.data[CTRL_START_BIT];
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            st <= idle;
        else
            st <= st_next;
    end

    // round counter
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            round <= '0;
        else if (st == idle)
            round <= '0;
        else if (st == end_round)
            round <= round + round_t'(1);
    end

    // runs through sub_bytes and the wait cycle
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            byte_cnt <= '0;
        else if ((st == sub_bytes) || (st == sub_wait))
            byte_cnt <= byte_cnt + byte_idx_t'(1);
        else
            byte_cnt <= '0;
    end

    always_comb
    begin
        st_next = st;
        case (st)
            idle:
                if (start)
                    st_next = add_key;
            add_key:
                // final key addition ends the run
                if (round == round_t'(NUM_ROUNDS))
                    st_next = done;
                else
                    st_next = load_ser;
            load_ser:
                st_next = sub_bytes;
            sub_bytes:
                if (byte_cnt == byte_idx_t'(STATE_BYTES - 1))
                    st_next = sub_wait;
            sub_wait:
                st_next = shift;
            shift:
                // collector holds shifted rows by now
                if (last_round)
                    st_next = store;
                else
                    st_next = mix;
            mix:
                st_next = store;
            store:
                st_next = end_round;
            end_round:
                st_next = add_key;
            done:
                st_next = idle;
            default:
                st_next = idle;
        endcase
    end

    // enables decoded from the state register
    always_comb
    begin
        dp.round = round;
        dp.ark_en = (st == add_key);
        dp.sel_plain = (round == '0);
        dp.ser_load = (st == load_ser);
        dp.ser_shift = (st == sub_bytes);
        // s-box output lags its address by one cycle
        dp.col_wr = (st == sub_wait) || ((st == sub_bytes) && (byte_cnt != '0));
        dp.mix_en = (st == mix);
        dp.store_en = (st == store);
        dp.store_sel = !last_round;
    end

endmodule

// File: aes_in_buffer.sv
// ------------------------------
// aes_in_buffer
// assembles plaintext from four
// written words
// ------------------------------
`timescale 1ns/1ps

module aes_in_buffer (
    input  logic             clk,
    input  logic             resetn,
    input  aes_pkg::write_t  wr,
    input  logic             busy,
    output aes_pkg::state_t  block
);
    import aes_pkg::*;

    // oldest word ends in column 0
    // writes while busy are dropped
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            block <= '0;
        else if (wr.valid && wr.addr && !busy)
            block <= {block[4:STATE_BYTES-1], wr.data};
    end

endmodule

// File: aes_mix_columns.sv
// ------------------------------
// aes_mix_columns
// mixcolumns on all four columns,
// registered
// ------------------------------
`timescale 1ns/1ps

module aes_mix_columns (
    input  logic              clk,
    input  logic              resetn,
    input  aes_pkg::dp_ctrl_t dp,
    input  aes_pkg::state_t   state_in,
    output aes_pkg::state_t   mixed
);
    import aes_pkg::*;

    state_t mix_next;

    // multiply by 2 in GF(2^8)
    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // matrix rows rotate 2 3 1 1
    function automatic word_t mix_col(input word_t col);
        byte_t a0;
        byte_t a1;
        byte_t a2;
        byte_t a3;
        word_t res;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        res[31:24] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
        res[23:16] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
        res[15:8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
        res[7:0] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        return res;
    endfunction

    always_comb
    begin
        for (int c = 0; c < 4; c++)
            mix_next[4*c +: 4] = mix_col(state_in[4*c +: 4]);
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            mixed <= '0;
        else if (dp.mix_en)
            mixed <= mix_next;
    end

endmodule

// File: aes_pkg.sv
// ------------------------------
// aes_pkg
// shared types, control encoding and the
// expanded round keys of the fixed key
// ------------------------------
package aes_pkg;

    // AES-256 round count
    localparam int NUM_ROUNDS = 14;
    localparam int STATE_BYTES = 16;
    // position of the start bit in the control word
    localparam int CTRL_START_BIT = 0;

    typedef logic [7:0] byte_t;
    typedef logic [31:0] word_t;

    // byte 0 in the top bits and bytes run column-major
    typedef byte_t [0:STATE_BYTES-1] state_t;

    // 0 to 14
    typedef logic [3:0] round_t;
    // s-box byte counter
    typedef logic [4:0] byte_idx_t;

    typedef enum logic [3:0] {
        idle      = 4'h0,
        add_key   = 4'h1,
        load_ser  = 4'h2,
        sub_bytes = 4'h3,
        sub_wait  = 4'h4,
        shift     = 4'h5,
        mix       = 4'h6,
        store     = 4'h7,
        end_round = 4'hc,
        done      = 4'hf
    } ctrl_st_e;

    // register write port
    typedef struct packed {
        logic  valid;
        logic  addr;
        word_t data;
    } write_t;

    // datapath enables from the control FSM
    typedef struct packed {
        logic   ark_en;
        logic   sel_plain;
        logic   ser_load;
        logic   ser_shift;
        logic   col_wr;
        logic   mix_en;
        logic   store_en;
        // 1 picks the mixed state
        logic   store_sel;
        round_t round;
    } dp_ctrl_t;

    // expanded key 000102..1f with one entry per round
    localparam state_t ROUND_KEYS [0:NUM_ROUNDS] = '{
        128'h000102030405060708090a0b0c0d0e0f,
        128'h101112131415161718191a1b1c1d1e1f,
        128'ha573c29fa176c498a97fce93a572c09c,
        128'h1651a8cd0244beda1a5da4c10640bade,
        128'hae87dff00ff11b68a68ed5fb03fc1567,
        128'h6de1f1486fa54f9275f8eb5373b8518d,
        128'hc656827fc9a799176f294cec6cd5598b,
        128'h3de23a75524775e727bf9eb45407cf39,
        128'h0bdc905fc27b0948ad5245a4c1871c2f,
        128'h45f5a66017b2d387300d4d33640a820a,
        128'h7ccff71cbeb4fe5413e6bbf0d261a7df,
        128'hf01afafee7a82979d7a5644ab3afe640,
        128'h2541fe719bf500258813bbd55a721c0a,
        128'h4e5a6699a9f24fe07e572baacdf8cdea,
        128'h24fc79ccbf0979e9371ac23c6d68de36
    };

endpackage

// File: aes_sbox_rom.sv
// ------------------------------
// aes_sbox_rom
// forward s-box, registered output
// ------------------------------
`timescale 1ns/1ps

module aes_sbox_rom (
    input  logic           clk,
    input  logic           resetn,
    input  aes_pkg::byte_t addr,
    output aes_pkg::byte_t data
);

    // one table row per high nibble
    logic [0:15][7:0] row;

    always_comb
    begin
        case (addr[7:4])
            4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
            4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
            4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
            4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
            4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
            4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
            4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
            4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
            4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
            4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
            4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
            4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
            4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
            4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
            4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
            default: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
        endcase
    end

    // low nibble picks the column
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            data <= '0;
        else
            data <= row[addr[3:0]];
    end

endmodule

// File: aes_sub_shift.sv
// ------------------------------
// aes_sub_shift
// byte serial subbytes through the s-box,
// bytes collected in shiftrows order
// ------------------------------
`timescale 1ns/1ps

module aes_sub_shift (
    input  logic              clk,
    input  logic              resetn,
    input  aes_pkg::dp_ctrl_t dp,
    input  aes_pkg::state_t   state_in,
    output aes_pkg::state_t   shifted
);
    import aes_pkg::*;

    state_t     ser;
    byte_idx_t  src_idx;
    byte_idx_t  src_idx_d;
    byte_t      sbox_out;
    logic [1:0] src_row;
    logic [1:0] src_col;
    logic [1:0] dst_col;

    // byte 0 of the serializer feeds the s-box
    always_ff @(posedge clk)
    begin
        if (dp.ser_load)
            ser <= state_in;
        else if (dp.ser_shift)
            ser <= {ser[1:STATE_BYTES-1], 8'h00};
    end

    // source index and a copy one cycle late
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            src_idx <= '0;
            src_idx_d <= '0;
        end
        else
        begin
            if (dp.ser_load)
                src_idx <= '0;
            else if (dp.ser_shift)
                src_idx <= src_idx + byte_idx_t'(1);
            src_idx_d <= src_idx;
        end
    end

    aes_sbox_rom i_sbox (
        .clk    (clk),
        .resetn (resetn),
        .addr   (ser[0]),
        .data   (sbox_out)
    );

    // row r moves r columns to the left
    assign src_row = src_idx_d[1:0];
    assign src_col = src_idx_d[3:2];
    assign dst_col = src_col - src_row;

    // collector
    always_ff @(posedge clk)
    begin
        if (dp.col_wr)
            shifted[{dst_col, src_row}] <= sbox_out;
    end

endmodule

// File: aes_testdata.txt
// each line holds a plaintext block and then its ciphertext, both 128-bit hex
// key is 000102..1f as held in the core's round-key table
00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089

// File: files.f
aes_pkg.sv
aes_sbox_rom.sv
aes_ctrl.sv
aes_in_buffer.sv
aes_sub_shift.sv
aes_mix_columns.sv
aes_add_round_key.sv
aes256_enc.sv
aes256_enc_tb.sv
